/* cpu_core.sv */
`timescale 1ns/100ps

module cpu_core (
    input  logic                     clk,
    input  logic                     reset,
    output logic [cpu_pkg::ADDR-1:0] imem_addr_o,
    input  logic [cpu_pkg::WORD-1:0] imem_data_i,
    output logic                     wb_valid_o,
    output cpu_pkg::wb_pkt_t         wb_o
);
    import cpu_pkg::*;

    // fetch to decode
    logic             f_v;
    fetch_pkt_t       f_pkt;
    logic             d_stall;

    // decode and scoreboard
    logic [W_RD-1:0]  rd_addr0, rd_addr1;
    logic [W_OPR-1:0] rd_opr0, rd_opr1;
    logic             rsv0, rsv1;
    logic             w_reserve;
    logic [W_RD-1:0]  dest;

    // decode to execute
    logic             d_v;
    issue_pkt_t       d_issue;
    logic             x_stall;

    // jump redirect
    logic             redirect;
    logic [ADDR-1:0]  target;

    // ----------------------------------------------------------------------
    // stages
    // ----------------------------------------------------------------------
    fetch_unit u_fetch (
        .clk         (clk),
        .reset       (reset),
        .stall_i     (d_stall),
        .redirect_i  (redirect),
        .target_i    (target),
        .imem_addr_o (imem_addr_o),
        .imem_data_i (imem_data_i),
        .v_o         (f_v),
        .pkt_o       (f_pkt)
    );

    decode_stage u_decode (
        .clk         (clk),
        .reset       (reset),
        .v_i         (f_v),
        .pkt_i       (f_pkt),
        .stall_o     (d_stall),
        .flush_i     (redirect),
        .r0_o        (rd_addr0),
        .r1_o        (rd_addr1),
        .r_opr0_i    (rd_opr0),
        .r_opr1_i    (rd_opr1),
        .reserved0_i (rsv0),
        .reserved1_i (rsv1),
        .w_reserve_o (w_reserve),
        .dest_o      (dest),
        .ex_i        (wb_valid_o),
        .ex_wb_i     (wb_o),
        .stall_i     (x_stall),
        .v_o         (d_v),
        .issue_o     (d_issue)
    );

    reg_scoreboard u_regs (
        .clk         (clk),
        .reset       (reset),
        .r0_i        (rd_addr0),
        .r1_i        (rd_addr1),
        .opr0_o      (rd_opr0),
        .opr1_o      (rd_opr1),
        .reserved0_o (rsv0),
        .reserved1_o (rsv1),
        .w_reserve_i (w_reserve),
        .dest_i      (dest),
        .wb_valid_i  (wb_valid_o),
        .wb_i        (wb_o)
    );

    execute_stage u_exec (
        .clk         (clk),
        .reset       (reset),
        .v_i         (d_v),
        .issue_i     (d_issue),
        .stall_o     (x_stall),
        .redirect_o  (redirect),
        .target_o    (target),
        .wb_valid_o  (wb_valid_o),
        .wb_o        (wb_o)
    );

endmodule

/* cpu_core_sva.sv */
`timescale 1ns/100ps

module cpu_core_sva (
    input logic                     clk,
    input logic                     reset,
    input logic                     fetch_stall_i,
    input logic                     redirect_i,
    input logic [cpu_pkg::ADDR-1:0] imem_addr_i,
    input logic                     issue_v_i,
    input logic                     exec_stall_i,
    input logic                     w_reserve_i,
    input cpu_pkg::issue_pkt_t      issue_i
);

    logic hold_failed  = 1'b0;
    logic busy_failed  = 1'b0;
    logic offer_failed = 1'b0;
    logic any_failed;
    logic mul_issue;

    assign any_failed = hold_failed | busy_failed | offer_failed;
    assign mul_issue  = w_reserve_i & issue_i.d_info.is_mul;

    // ----------------------------------------------------------------------
    // fetch to decode
    // ----------------------------------------------------------------------
    a_fetch_hold: assert property (@(posedge clk) disable iff (!reset)
        fetch_stall_i && !redirect_i |=> $stable(imem_addr_i))
    else begin
        hold_failed = 1'b1;
        $error("imem_addr_o moved while fetch was stalled");
    end

    // ----------------------------------------------------------------------
    // decode to execute
    // ----------------------------------------------------------------------
    // execute holds decode off for exactly the two cycles after a multiply issues
    a_mul_busy: assert property (@(posedge clk) disable iff (!reset)
        exec_stall_i == ($past(mul_issue, 1) || $past(mul_issue, 2)))
    else begin
        busy_failed = 1'b1;
        $error("execute stall did not match the multiply in flight");
    end

    // a refused offer stays up with the same instruction
    a_offer_hold: assert property (@(posedge clk) disable iff (!reset)
        issue_v_i && exec_stall_i |=> issue_v_i && $stable(issue_i.pc))
    else begin
        offer_failed = 1'b1;
        $error("decode dropped or changed its offer while execute was stalled");
    end

endmodule

/* cpu_pkg.sv */
package cpu_pkg;

    // ----------------------------------------------------------------------
    // widths
    // ----------------------------------------------------------------------
    localparam int WORD       = 16;
    localparam int ADDR       = 8;
    localparam int W_OP       = 4;
    localparam int W_RD       = 3;
    localparam int W_IMM      = 6;
    localparam int W_OPR      = 16;
    localparam int N_REG      = 8;
    localparam int MUL_CYCLES = 3;

    // ----------------------------------------------------------------------
    // instruction encoding
    // ----------------------------------------------------------------------
    typedef enum logic [W_OP-1:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_ADDI = 4'd3,
        OP_LI   = 4'd4,
        OP_MUL  = 4'd5,
        OP_JMP  = 4'd6
    } opcode_t;

    // msb first, r0 doubles as the destination
    typedef struct packed {
        opcode_t          op;
        logic [W_RD-1:0]  r0;
        logic [W_RD-1:0]  r1;
        logic [W_IMM-1:0] imm;
    } inst_t;

    typedef enum logic [1:0] {
        ALU_ADD  = 2'd0,
        ALU_SUB  = 2'd1,
        ALU_PASS = 2'd2
    } alu_op_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    use_r0;
        logic    use_r1;
        logic    use_imm;
        logic    writes_reg;
        logic    is_mul;
        logic    is_jmp;
    } d_info_t;

    // ----------------------------------------------------------------------
    // stage payloads
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [ADDR-1:0] pc;
        logic [WORD-1:0] inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic [ADDR-1:0]  pc;
        d_info_t          d_info;
        logic [W_RD-1:0]  dest;
        logic [W_OPR-1:0] opr0;
        logic [W_OPR-1:0] opr1;
        logic [W_OPR-1:0] imm;
    } issue_pkt_t;

    typedef struct packed {
        logic [W_RD-1:0]  rd;
        logic [W_OPR-1:0] data;
    } wb_pkt_t;

endpackage

/* decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      v_i,
    input  cpu_pkg::fetch_pkt_t       pkt_i,
    output logic                      stall_o,
    input  logic                      flush_i,
    output logic [cpu_pkg::W_RD-1:0]  r0_o,
    output logic [cpu_pkg::W_RD-1:0]  r1_o,
    input  logic [cpu_pkg::W_OPR-1:0] r_opr0_i,
    input  logic [cpu_pkg::W_OPR-1:0] r_opr1_i,
    input  logic                      reserved0_i,
    input  logic                      reserved1_i,
    output logic                      w_reserve_o,
    output logic [cpu_pkg::W_RD-1:0]  dest_o,
    input  logic                      ex_i,
    input  cpu_pkg::wb_pkt_t          ex_wb_i,
    input  logic                      stall_i,
    output logic                      v_o,
    output cpu_pkg::issue_pkt_t       issue_o
);
    import cpu_pkg::*;

    function automatic d_info_t decode_op(opcode_t op);
        d_info_t d;
        d = '0;
        case (op)
            OP_ADD, OP_SUB, OP_MUL: begin
                d.use_r0     = 1'b1;
                d.use_r1     = 1'b1;
                d.writes_reg = 1'b1;
                d.alu_op     = (op == OP_SUB) ? ALU_SUB : ALU_ADD;
                d.is_mul     = (op == OP_MUL);
            end
            OP_ADDI: begin
                d.use_r0     = 1'b1;
                d.use_imm    = 1'b1;
                d.writes_reg = 1'b1;
            end
            OP_LI: begin
                d.use_imm    = 1'b1;
                d.writes_reg = 1'b1;
                d.alu_op     = ALU_PASS;
            end
            OP_JMP: begin
                d.use_imm = 1'b1;
                d.is_jmp  = 1'b1;
            end
            default: d = '0;
        endcase
        return d;
    endfunction

    logic             v_r;
    logic [ADDR-1:0]  pc_r;
    d_info_t          d_info_r;
    logic [W_RD-1:0]  r0_r;
    logic [W_RD-1:0]  r1_r;
    logic [W_OPR-1:0] imm_r;

    inst_t            in_inst;
    d_info_t          in_info;
    logic [W_OPR-1:0] in_imm;

    logic             fwd0, fwd1;
    logic             wait0, wait1;
    logic             hazard;
    logic [W_OPR-1:0] opr0, opr1;

    assign in_inst = pkt_i.inst;
    assign in_info = decode_op(in_inst.op);
    // jmp carries an unsigned absolute target in the low bits
    assign in_imm  = in_info.is_jmp ? W_OPR'(pkt_i.inst[ADDR-1:0]) :
                     {{(W_OPR-W_IMM){in_inst.imm[W_IMM-1]}}, in_inst.imm};

    // ----------------------------------------------------------------------
    // reservation check and forwarding
    // ----------------------------------------------------------------------
    assign r0_o  = r0_r;
    assign r1_o  = r1_r;
    assign fwd0  = ex_i & (ex_wb_i.rd == r0_r);
    assign fwd1  = ex_i & (ex_wb_i.rd == r1_r);
    assign wait0 = d_info_r.use_r0 & reserved0_i & ~fwd0;
    assign wait1 = d_info_r.use_r1 & reserved1_i & ~fwd1;
    assign hazard = v_r & (wait0 | wait1);
    assign opr0  = fwd0 ? ex_wb_i.data : r_opr0_i;
    assign opr1  = fwd1 ? ex_wb_i.data : r_opr1_i;

    assign stall_o     = v_r & ~flush_i & (stall_i | hazard);
    assign v_o         = v_r & ~flush_i & ~hazard;
    assign w_reserve_o = v_o & ~stall_i & d_info_r.writes_reg;
    assign dest_o      = r0_r;

    assign issue_o = '{pc: pc_r, d_info: d_info_r, dest: r0_r,
                       opr0: opr0, opr1: opr1, imm: imm_r};

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            v_r <= 1'b0;
        end else if (flush_i) begin
            v_r <= 1'b0;
        end else if (!stall_o) begin
            v_r <= v_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_o && !flush_i && v_i) begin
            pc_r     <= pkt_i.pc;
            d_info_r <= in_info;
            r0_r     <= in_inst.r0;
            r1_r     <= in_inst.r1;
            imm_r    <= in_imm;
        end
    end

endmodule

/* execute_stage.sv */
`timescale 1ns/100ps

module execute_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     v_i,
    input  cpu_pkg::issue_pkt_t      issue_i,
    output logic                     stall_o,
    output logic                     redirect_o,
    output logic [cpu_pkg::ADDR-1:0] target_o,
    output logic                     wb_valid_o,
    output cpu_pkg::wb_pkt_t         wb_o
);
    import cpu_pkg::*;

    logic             accept;
    logic [W_OPR-1:0] op_b;
    logic [W_OPR-1:0] alu_res;
    logic             alu_wb;

    // multiplier pipe
    logic             m1_v, m2_v;
    logic [W_RD-1:0]  m1_rd, m2_rd;
    logic [W_OPR-1:0] m1_a, m1_b;
    logic [W_OPR-1:0] m2_prod;

    logic             wb_v_r;
    wb_pkt_t          wb_r;
    logic             redirect_r;
    logic [ADDR-1:0]  target_r;

    // busy until the product reaches the write-back register
    assign stall_o = m1_v | m2_v;
    assign accept  = v_i & ~stall_o;

    assign op_b   = issue_i.d_info.use_imm ? issue_i.imm : issue_i.opr1;
    assign alu_wb = accept & issue_i.d_info.writes_reg & ~issue_i.d_info.is_mul;

    // ----------------------------------------------------------------------
    // single-cycle ALU
    // ----------------------------------------------------------------------
    always_comb begin
        case (issue_i.d_info.alu_op)
            ALU_ADD:  alu_res = issue_i.opr0 + op_b;
            ALU_SUB:  alu_res = issue_i.opr0 - op_b;
            ALU_PASS: alu_res = op_b;
            default:  alu_res = '0;
        endcase
    end

    // ----------------------------------------------------------------------
    // control
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            m1_v       <= 1'b0;
            m2_v       <= 1'b0;
            wb_v_r     <= 1'b0;
            redirect_r <= 1'b0;
        end else begin
            m1_v       <= accept & issue_i.d_info.is_mul;
            m2_v       <= m1_v;
            wb_v_r     <= m2_v | alu_wb;
            redirect_r <= accept & issue_i.d_info.is_jmp;
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        m1_a     <= issue_i.opr0;
        m1_b     <= issue_i.opr1;
        m1_rd    <= issue_i.dest;
        // low half of the product only
        m2_prod  <= m1_a * m1_b;
        m2_rd    <= m1_rd;
        target_r <= issue_i.imm[ADDR-1:0];
        if (m2_v) begin
            wb_r.rd   <= m2_rd;
            wb_r.data <= m2_prod;
        end else begin
            wb_r.rd   <= issue_i.dest;
            wb_r.data <= alu_res;
        end
    end

    assign wb_valid_o = wb_v_r;
    assign wb_o       = wb_r;
    assign redirect_o = redirect_r;
    assign target_o   = target_r;

endmodule

/* fetch_unit.sv */
`timescale 1ns/100ps

module fetch_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     stall_i,
    input  logic                     redirect_i,
    input  logic [cpu_pkg::ADDR-1:0] target_i,
    output logic [cpu_pkg::ADDR-1:0] imem_addr_o,
    input  logic [cpu_pkg::WORD-1:0] imem_data_i,
    output logic                     v_o,
    output cpu_pkg::fetch_pkt_t      pkt_o
);
    import cpu_pkg::*;

    logic [ADDR-1:0] pc_r;
    logic            v_r;
    fetch_pkt_t      pkt_r;
    logic            advance;

    // memory answers in the same cycle, so the pc is the request
    assign imem_addr_o = pc_r;
    assign v_o         = v_r;
    assign pkt_o       = pkt_r;

    assign advance = ~redirect_i & ~stall_i;

    // ----------------------------------------------------------------------
    // program counter and valid
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_r <= '0;
            v_r  <= 1'b0;
        end else if (redirect_i) begin
            // bubble for the cycle the target is requested
            pc_r <= target_i;
            v_r  <= 1'b0;
        end else if (!stall_i) begin
            pc_r <= pc_r + 1'b1;
            v_r  <= 1'b1;
        end
    end

    // packet register
    always_ff @(posedge clk) begin
        if (advance) begin
            pkt_r.pc   <= pc_r;
            pkt_r.inst <= imem_data_i;
        end
    end

endmodule

/* flist.f */
cpu_pkg.sv
fetch_unit.sv
decode_stage.sv
reg_scoreboard.sv
execute_stage.sv
cpu_core.sv
cpu_core_sva.sv
tb_cpu_core.sv

/* reg_scoreboard.sv */
`timescale 1ns/100ps

module reg_scoreboard (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [cpu_pkg::W_RD-1:0]  r0_i,
    input  logic [cpu_pkg::W_RD-1:0]  r1_i,
    output logic [cpu_pkg::W_OPR-1:0] opr0_o,
    output logic [cpu_pkg::W_OPR-1:0] opr1_o,
    output logic                      reserved0_o,
    output logic                      reserved1_o,
    input  logic                      w_reserve_i,
    input  logic [cpu_pkg::W_RD-1:0]  dest_i,
    input  logic                      wb_valid_i,
    input  cpu_pkg::wb_pkt_t          wb_i
);
    import cpu_pkg::*;

    logic [W_OPR-1:0] regs [N_REG];
    logic [N_REG-1:0] rsv;
    logic [N_REG-1:0] set_mask;
    logic [N_REG-1:0] clr_mask;

    // ----------------------------------------------------------------------
    // read ports
    // ----------------------------------------------------------------------
    assign opr0_o      = regs[r0_i];
    assign opr1_o      = regs[r1_i];
    assign reserved0_o = rsv[r0_i];
    assign reserved1_o = rsv[r1_i];

    // ----------------------------------------------------------------------
    // reservation bits
    // ----------------------------------------------------------------------
    always_comb begin
        set_mask = '0;
        clr_mask = '0;
        if (w_reserve_i) begin
            set_mask[dest_i] = 1'b1;
        end
        if (wb_valid_i) begin
            clr_mask[wb_i.rd] = 1'b1;
        end
    end

    // a reserve on the register being written back stays set
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rsv <= '0;
        end else begin
            rsv <= (rsv & ~clr_mask) | set_mask;
        end
    end

    // register file
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < N_REG; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid_i) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu_core \
    -f flist.f -o tb_cpu_core \
    || { echo "build failed"; exit 1; }
./obj_dir/tb_cpu_core 2>&1 | tee sim.log
grep -q "ALL CHECKS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* tb_cpu_core.sv */
`timescale 1ns/100ps

module tb_cpu_core;
    import cpu_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int RUN_LIMIT    = RESET_CYCLES + 4 * 256 * MUL_CYCLES;
    // fetch, decode and execute registers
    localparam int FILL_EDGES   = 3;
    localparam int DRAIN_CYCLES = 20;

    localparam logic [1:0] K_PLAIN     = 2'd0;
    localparam logic [1:0] K_MUL_FWD   = 2'd1;
    localparam logic [1:0] K_AFTER_JMP = 2'd2;

    typedef struct packed {
        logic [1:0]       kind;
        logic [W_RD-1:0]  rd;
        logic [W_OPR-1:0] data;
    } exp_wb_t;

    logic             clk;
    logic             reset;
    logic [ADDR-1:0]  imem_addr;
    logic [WORD-1:0]  imem_data;
    logic             wb_valid;
    wb_pkt_t          wb;

    logic [WORD-1:0]  mem [256];
    logic [W_OPR-1:0] arch [N_REG];
    exp_wb_t          exp_q [$];
    exp_wb_t          exp_now;
    integer           seed;
    int               fill_cnt = 0;
    int               cycles = 0;

    cpu_core u_dut (
        .clk         (clk),
        .reset       (reset),
        .imem_addr_o (imem_addr),
        .imem_data_i (imem_data),
        .wb_valid_o  (wb_valid),
        .wb_o        (wb)
    );

    bind cpu_core cpu_core_sva u_sva (
        .clk           (clk),
        .reset         (reset),
        .fetch_stall_i (d_stall),
        .redirect_i    (redirect),
        .imem_addr_i   (imem_addr_o),
        .issue_v_i     (d_v),
        .exec_stall_i  (x_stall),
        .w_reserve_i   (w_reserve),
        .issue_i       (d_issue)
    );

    // instruction memory answers in the same cycle
    assign imem_data = mem[imem_addr];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string sig, input logic [W_OPR-1:0] got,
                                   input logic [W_OPR-1:0] want);
        stop_run($sformatf("** Error: %s = 0x%04h, expected 0x%04h", sig, got, want));
    endtask

    function automatic logic [WORD-1:0] encode(opcode_t op, int r0, int r1, int imm);
        inst_t w;
        w.op  = op;
        w.r0  = r0[W_RD-1:0];
        w.r1  = r1[W_RD-1:0];
        w.imm = imm[W_IMM-1:0];
        return w;
    endfunction

    // does instruction w read register r as a source
    function automatic logic reads_reg(logic [WORD-1:0] w, logic [W_RD-1:0] r);
        case (w[15:12])
            OP_ADD, OP_SUB, OP_MUL: return (w[11:9] == r) || (w[8:6] == r);
            OP_ADDI: return w[11:9] == r;
            default: return 1'b0;
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // program: fixed prologue, random body, self jump at the end
    // ----------------------------------------------------------------------
    task automatic fill_program();
        int rnd;
        int op_sel;
        int tgt;
        mem[0] = encode(OP_LI, 1, 0, 5);
        mem[1] = encode(OP_LI, 2, 0, -3);
        mem[2] = encode(OP_MUL, 1, 2, 0);
        mem[3] = encode(OP_ADD, 1, 2, 0);
        mem[4] = encode(OP_JMP, 0, 0, 8);
        // skipped by the jump
        mem[5] = encode(OP_LI, 3, 0, 1);
        mem[6] = encode(OP_LI, 4, 0, 2);
        mem[7] = encode(OP_ADDI, 3, 0, 3);
        mem[8] = encode(OP_LI, 5, 0, 7);
        for (int a = 9; a < 255; a++) begin
            op_sel = $unsigned($random(seed)) % 7;
            rnd    = $random(seed);
            mem[a] = rnd[15:0];
            mem[a][15:12] = op_sel[3:0];
            if (op_sel == int'(OP_JMP)) begin
                // short forward hops only
                tgt = a + 1 + $unsigned($random(seed)) % 8;
                if (tgt > 255) begin
                    tgt = 255;
                end
                mem[a][7:0] = tgt[7:0];
            end
        end
        mem[255] = {OP_JMP, 4'h0, 8'hff};
    endtask

    // architectural model, one instruction at a time in program order
    task automatic build_expected();
        int               pc;
        logic [WORD-1:0]  w;
        logic [W_RD-1:0]  rd;
        logic [W_OPR-1:0] a;
        logic [W_OPR-1:0] b;
        logic [W_OPR-1:0] simm;
        logic [W_OPR-1:0] res;
        logic             writes;
        logic             after_jmp;
        logic             done;
        exp_wb_t          e;
        for (int i = 0; i < N_REG; i++) begin
            arch[i] = '0;
        end
        pc        = 0;
        after_jmp = 1'b0;
        done      = 1'b0;
        while (!done) begin
            w      = mem[pc];
            rd     = w[11:9];
            a      = arch[w[11:9]];
            b      = arch[w[8:6]];
            simm   = {{(W_OPR-W_IMM){w[5]}}, w[5:0]};
            res    = '0;
            writes = 1'b1;
            case (w[15:12])
                OP_ADD:  res = a + b;
                OP_SUB:  res = a - b;
                OP_ADDI: res = a + simm;
                OP_LI:   res = simm;
                OP_MUL:  res = a * b;
                default: writes = 1'b0;
            endcase
            if (writes) begin
                e.rd   = rd;
                e.data = res;
                e.kind = after_jmp ? K_AFTER_JMP : K_PLAIN;
                if (w[15:12] == OP_MUL && reads_reg(mem[pc+1], rd)) begin
                    e.kind = K_MUL_FWD;
                end
                arch[rd] = res;
                exp_q.push_back(e);
                after_jmp = 1'b0;
            end
            if (w[15:12] == OP_JMP) begin
                if (int'(w[7:0]) == pc) begin
                    done = 1'b1;
                end else begin
                    pc        = int'(w[7:0]);
                    after_jmp = 1'b1;
                end
            end else begin
                pc++;
            end
        end
    endtask

    always @(posedge clk or negedge reset) begin
        if (!reset) begin
            fill_cnt <= 0;
        end else if (fill_cnt < FILL_EDGES) begin
            fill_cnt <= fill_cnt + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= RUN_LIMIT) begin
            stop_run($sformatf("timeout after %0d cycles, %0d write-backs never came",
                               cycles, exp_q.size()));
        end
    end

    // ----------------------------------------------------------------------
    // write-back checks, sampled away from the rising edge
    // ----------------------------------------------------------------------
    always @(negedge clk) begin
        a_protocol: assert (!u_dut.u_sva.any_failed)
            else stop_run("a handshake assertion on the pipeline failed");
        if (wb_valid) begin
            a_fill: assert (fill_cnt >= FILL_EDGES)
                else stop_run("write-back seen before the first instruction could retire");
            a_extra: assert (exp_q.size() != 0)
                else stop_run("an instruction retired that the program never reaches");
            if (exp_q.size() != 0) begin
                exp_now = exp_q.pop_front();
                if (exp_now.kind == K_MUL_FWD) begin
                    a_mul_fwd: assert (wb.data == exp_now.data)
                        else report_mismatch("wb_o.data of MUL used next", wb.data,
                                             exp_now.data);
                end
                if (exp_now.kind == K_AFTER_JMP) begin
                    a_jmp_target: assert (wb.rd == exp_now.rd)
                        else report_mismatch("wb_o.rd first after JMP", W_OPR'(wb.rd),
                                             W_OPR'(exp_now.rd));
                end
                a_rd: assert (wb.rd == exp_now.rd)
                    else report_mismatch("wb_o.rd", W_OPR'(wb.rd), W_OPR'(exp_now.rd));
                a_data: assert (wb.data == exp_now.data)
                    else report_mismatch("wb_o.data", wb.data, exp_now.data);
            end
        end
    end

    initial begin
        seed  = 17;
        reset = 1'b0;
        fill_program();
        build_expected();
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b1;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        // the final self jump must retire nothing more
        repeat (DRAIN_CYCLES) @(negedge clk);
        @(posedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
